// File: pkt_decoder.f
+incdir+verilog
verilog/pkt_decoder_pkg.sv
verilog/pkt_decoder_ifs.sv
verilog/pkt_ingress.sv
verilog/pkt_buffer.sv
verilog/pkt_egress.sv
verilog/stats_arbiter.sv
verilog/stats_bank.sv
verilog/pkt_decoder_top.sv
verification/pkt_decoder_tb.sv

// File: verification/pkt_decoder_tb.sv
`timescale 1ns/10ps
`include "pkt_decoder_params.svh"

module pkt_decoder_tb;
  import pkt_decoder_pkg::*;

  localparam int NPKT      = 40;
  localparam int NPKT_P1   = 32;  // Packets before the counter clear
  localparam int MAX_BEATS = 6;

  localparam reg_addr_t ADDR_IN_PKTS    = 3'b000;
  localparam reg_addr_t ADDR_IN_BYTES   = 3'b001;
  localparam reg_addr_t ADDR_PASS_PKTS  = 3'b010;
  localparam reg_addr_t ADDR_PASS_BYTES = 3'b011;
  localparam reg_addr_t ADDR_DROP_PKTS  = 3'b100;
  localparam reg_addr_t ADDR_DROP_BYTES = 3'b101;

  // Source ports and where each one forwards to
  localparam port_t SRC_PORTS [8] = '{`PORT_NIC0, `PORT_NIC1, `PORT_NIC2, `PORT_NIC3,
                                      `PORT_CPU0, `PORT_CPU1, `PORT_CPU2, `PORT_CPU3};
  localparam port_t DST_PORTS [8] = '{`PORT_NIC1, `PORT_NIC0, `PORT_NIC3, `PORT_NIC2,
                                      `PORT_CPU1, `PORT_CPU0, `PORT_CPU3, `PORT_CPU2};

  logic axi_aclk = 1'b0;
  logic rst;
  data_t s_axis_tdata;
  keep_t s_axis_tkeep;
  port_t s_axis_tuser;
  logic s_axis_tvalid, s_axis_tlast, s_axis_tready;
  data_t m_hdr_tdata;
  pkt_id_t m_hdr_tid;
  logic m_hdr_tvalid, m_hdr_tready;
  logic s_dec_pass, s_dec_tvalid, s_dec_tready;
  pkt_id_t s_dec_id;
  data_t m_axis_tdata;
  keep_t m_axis_tkeep;
  port_t m_axis_tuser;
  logic m_axis_tvalid, m_axis_tlast, m_axis_tready;
  logic reg_req, reg_wr, reg_ack;
  reg_addr_t reg_addr;
  count_t reg_wdata, reg_rdata;

  // Packet set built once at time zero
  data_t beat_data [NPKT][MAX_BEATS];
  keep_t beat_keep [NPKT][MAX_BEATS];
  int    pkt_len   [NPKT];
  int    pkt_bytes [NPKT];
  port_t pkt_src   [NPKT];
  bit    pkt_pass  [NPKT];
  bit    pkt_bad_id[NPKT];     // Filter sends a wrong id first

  logic [80:0] exp_q [$];      // {last, user, keep, data}
  logic [2:0]  dec_q [$];      // {pass, id}
  logic [31:0] rng_state = 32'h2278;
  int hdr_idx = 0;
  int out_idx = 0;
  int stall_left = 0;
  int stall_run = 0;
  bit dec_taken = 1'b0;
  bit in_seen = 1'b0;
  bit first_stall = 1'b0;
  bit saw_full = 1'b0;

  pkt_decoder_top i_dut (.*);

  always #5 axi_aclk = ~axi_aclk;

  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  // Byte order flipped inside each IP address
  function automatic data_t ip_swapped(input data_t d);
    return {d[39:32], d[47:40], d[55:48], d[63:56], d[7:0], d[15:8], d[23:16], d[31:24]};
  endfunction

  function automatic port_t dest_port(input port_t src);
    port_t dst;
    dst = '0;
    for (int i = 0; i < 8; i++) begin
      if (SRC_PORTS[i] == src) dst = DST_PORTS[i];
    end
    return dst;
  endfunction

  // kind 0 counts all packets and 1 or 2 only the passed or dropped ones
  function automatic count_t stat_sum(input int lo, input int hi, input int kind, input bit bytes);
    count_t sum;
    sum = '0;
    for (int p = lo; p < hi; p++) begin
      if (kind == 0 || (kind == 1 && pkt_pass[p]) || (kind == 2 && !pkt_pass[p])) begin
        sum += bytes ? count_t'(pkt_bytes[p]) : count_t'(1);
      end
    end
    return sum;
  endfunction

  task automatic report_error(input string msg);
    $display("** Error at %0t ns: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  //////////////////////////////
  // Stimulus generation
  //////////////////////////////
  task automatic build_packets();
    for (int p = 0; p < NPKT; p++) begin
      pkt_len[p]    = 1 + int'(next_rand() % 6);
      pkt_src[p]    = SRC_PORTS[next_rand() % 8];
      pkt_pass[p]   = (next_rand() % 3) != 0;
      pkt_bad_id[p] = (next_rand() % 6) == 0;
      pkt_bytes[p]  = 0;
      for (int b = 0; b < pkt_len[p]; b++) begin
        beat_data[p][b] = {next_rand(), next_rand()};
        beat_keep[p][b] = (b == pkt_len[p] - 1) ? (8'hff >> (next_rand() % 8)) : 8'hff;
        pkt_bytes[p] += $countones(beat_keep[p][b]);
        if (pkt_pass[p]) begin
          exp_q.push_back({b == pkt_len[p] - 1, dest_port(pkt_src[p]),
                           beat_keep[p][b], beat_data[p][b]});
        end
      end
    end
  endtask

  task automatic send_packet(input int p);
    for (int b = 0; b < pkt_len[p]; b++) begin
      s_axis_tdata  = beat_data[p][b];
      s_axis_tkeep  = beat_keep[p][b];
      s_axis_tuser  = pkt_src[p];
      s_axis_tlast  = (b == pkt_len[p] - 1);
      s_axis_tvalid = 1'b1;
      do begin
        @(negedge axi_aclk);
      end while (!s_axis_tready);
      @(posedge axi_aclk);
      #1;
    end
    s_axis_tvalid = 1'b0;
  endtask

  // Called and returns 1 ns after a rising edge
  task automatic host_access(input bit wr, input reg_addr_t addr, input count_t wdata,
                             output count_t rdata);
    reg_req   = 1'b1;
    reg_wr    = wr;
    reg_addr  = addr;
    reg_wdata = wdata;
    do begin
      @(negedge axi_aclk);
    end while (!reg_ack);
    rdata = reg_rdata;
    @(posedge axi_aclk);
    #1;
    reg_req = 1'b0;
  endtask

  task automatic expect_counter(input reg_addr_t addr, input count_t exp, input string what);
    count_t got;
    host_access(1'b0, addr, '0, got);
    assert (got == exp)
      else report_error($sformatf("%s read %0d, expected %0d", what, got, exp));
  endtask

  // Polls until every sent packet has reached a pass or drop counter
  task automatic wait_all_decided(input int total);
    count_t n_pass;
    count_t n_drop;
    n_pass = '0;
    n_drop = '0;
    while (int'(n_pass + n_drop) != total) begin
      host_access(1'b0, ADDR_PASS_PKTS, '0, n_pass);
      host_access(1'b0, ADDR_DROP_PKTS, '0, n_drop);
    end
  endtask

  task automatic check_idle_outputs(input string when);
    assert (!s_axis_tready && !m_hdr_tvalid && !s_dec_tready && !m_axis_tvalid && !reg_ack)
      else report_error({"control output high ", when});
  endtask

  //////////////////////////////
  // Filter and sink models
  //////////////////////////////
  always @(negedge axi_aclk) begin
    if (!rst) begin
      dec_taken = s_dec_tvalid && s_dec_tready;
      if (m_hdr_tvalid && m_hdr_tready) begin
        assert (hdr_idx < NPKT) else report_error("header seen with no packet left");
        assert (m_hdr_tdata == ip_swapped(beat_data[hdr_idx][0]))
          else report_error($sformatf("header %0d data %h", hdr_idx, m_hdr_tdata));
        assert (m_hdr_tid == pkt_id_t'(hdr_idx))
          else report_error($sformatf("header %0d id %0d", hdr_idx, m_hdr_tid));
        if (pkt_bad_id[hdr_idx]) begin
          dec_q.push_back({~pkt_pass[hdr_idx], m_hdr_tid + 2'd1});
        end
        dec_q.push_back({pkt_pass[hdr_idx], m_hdr_tid});
        hdr_idx++;
      end
    end
  end

  always @(posedge axi_aclk) begin
    #1;
    if (dec_taken || !s_dec_tvalid) begin
      if (dec_q.size() > 0) begin
        {s_dec_pass, s_dec_id} = dec_q.pop_front();
        s_dec_tvalid = 1'b1;
      end else begin
        s_dec_tvalid = 1'b0;
      end
    end
  end

  always @(negedge axi_aclk) begin
    if (!rst && m_axis_tvalid && m_axis_tready) begin
      assert (exp_q.size() > 0) else report_error("output beat with none expected");
      assert ({m_axis_tlast, m_axis_tuser, m_axis_tkeep, m_axis_tdata} == exp_q[0])
        else report_error($sformatf("output beat %0d is %h, expected %h", out_idx,
                          {m_axis_tlast, m_axis_tuser, m_axis_tkeep, m_axis_tdata}, exp_q[0]));
      void'(exp_q.pop_front());
      out_idx++;
    end
    // Long output stall with input held off means the buffer filled
    stall_run = (m_axis_tvalid && !m_axis_tready) ? stall_run + 1 : 0;
    if (s_axis_tvalid && !s_axis_tready && stall_run > `BUF_DEPTH) saw_full = 1'b1;
    if (s_axis_tvalid) in_seen = 1'b1;
  end

  // Sink and filter ready with one long output stall up front then random ones
  always @(posedge axi_aclk) begin
    #1;
    if (!rst) begin
      if (in_seen && !first_stall) begin
        stall_left  = 64;
        first_stall = 1'b1;
      end else if (stall_left == 0 && next_rand() % 48 == 0) begin
        stall_left = 20 + int'(next_rand() % 20);
      end
      if (stall_left > 0) begin
        m_axis_tready = 1'b0;
        stall_left--;
      end else begin
        m_axis_tready = (next_rand() % 4) != 0;
      end
      m_hdr_tready = (next_rand() % 3) != 0;  // Filter busy now and then
    end
  end

  out_hold: assert property (@(negedge axi_aclk) disable iff (rst)
    (m_axis_tvalid && !m_axis_tready) |=> (m_axis_tvalid
      && $stable({m_axis_tdata, m_axis_tkeep, m_axis_tuser, m_axis_tlast})))
    else report_error("output beat changed while stalled");

  hdr_hold: assert property (@(negedge axi_aclk) disable iff (rst)
    (m_hdr_tvalid && !m_hdr_tready) |=> (m_hdr_tvalid && $stable({m_hdr_tdata, m_hdr_tid})))
    else report_error("header changed while stalled");

  initial begin : watchdog
    repeat (NPKT * 200) @(posedge axi_aclk);
    $display("Watchdog expired after %0d cycles, the traffic did not complete", NPKT * 200);
    $display("TEST FAILED");
    $fatal(1, "timeout");
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    count_t dummy;
    rst = 1'b1;
    s_axis_tdata = '0;
    s_axis_tkeep = '0;
    s_axis_tuser = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tlast = 1'b0;
    m_hdr_tready = 1'b1;
    s_dec_pass = 1'b0;
    s_dec_id = '0;
    s_dec_tvalid = 1'b0;
    m_axis_tready = 1'b0;
    reg_req = 1'b0;
    reg_wr = 1'b0;
    reg_addr = '0;
    reg_wdata = '0;
    build_packets();

    repeat (7) @(posedge axi_aclk);
    @(negedge axi_aclk);
    check_idle_outputs("during reset");
    @(posedge axi_aclk);
    #1;
    rst = 1'b0;
    @(negedge axi_aclk);
    check_idle_outputs("after reset");
    @(posedge axi_aclk);
    #1;
    for (int a = 0; a < 6; a++) begin
      expect_counter(reg_addr_t'(a), '0, $sformatf("counter %0d after reset", a));
    end

    for (int p = 0; p < NPKT_P1; p++) send_packet(p);
    wait_all_decided(NPKT_P1);
    expect_counter(ADDR_IN_PKTS, stat_sum(0, NPKT_P1, 0, 0), "in packets");
    expect_counter(ADDR_IN_BYTES, stat_sum(0, NPKT_P1, 0, 1), "in bytes");
    expect_counter(ADDR_PASS_PKTS, stat_sum(0, NPKT_P1, 1, 0), "pass packets");
    expect_counter(ADDR_PASS_BYTES, stat_sum(0, NPKT_P1, 1, 1), "pass bytes");
    expect_counter(ADDR_DROP_PKTS, stat_sum(0, NPKT_P1, 2, 0), "drop packets");
    expect_counter(ADDR_DROP_BYTES, stat_sum(0, NPKT_P1, 2, 1), "drop bytes");

    // Clear one half of two entries while the other halves keep counting
    host_access(1'b1, ADDR_IN_PKTS, '0, dummy);
    host_access(1'b1, ADDR_DROP_BYTES, '0, dummy);
    expect_counter(ADDR_IN_PKTS, '0, "in packets after clear");
    expect_counter(ADDR_IN_BYTES, stat_sum(0, NPKT_P1, 0, 1), "in bytes after clear");

    for (int p = NPKT_P1; p < NPKT; p++) send_packet(p);
    wait_all_decided(NPKT);
    expect_counter(ADDR_IN_PKTS, stat_sum(NPKT_P1, NPKT, 0, 0), "in packets rebuilt");
    expect_counter(ADDR_IN_BYTES, stat_sum(0, NPKT, 0, 1), "in bytes total");
    expect_counter(ADDR_PASS_PKTS, stat_sum(0, NPKT, 1, 0), "pass packets total");
    expect_counter(ADDR_PASS_BYTES, stat_sum(0, NPKT, 1, 1), "pass bytes total");
    expect_counter(ADDR_DROP_PKTS, stat_sum(0, NPKT, 2, 0), "drop packets total");
    expect_counter(ADDR_DROP_BYTES, stat_sum(NPKT_P1, NPKT, 2, 1), "drop bytes rebuilt");

    assert (hdr_idx == NPKT) else report_error("not every header reached the filter");
    assert (dec_q.size() == 0) else report_error("decisions left unconsumed");
    assert (exp_q.size() == 0) else report_error("expected output beats never arrived");
    assert (saw_full) else report_error("input was never held off by a full buffer");
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: verilog/pkt_buffer.sv
`timescale 1ns/10ps
`include "pkt_decoder_params.svh"

module pkt_buffer (
  input logic    axi_aclk,
  input logic    rst,
  buf_wr_if.sink buf_wr,
  buf_rd_if.src  buf_rd
);
  import pkt_decoder_pkg::*;

  localparam int AW = $clog2(`BUF_DEPTH);

  // Beat storage
  data_t   mem_data [`BUF_DEPTH];
  keep_t   mem_keep [`BUF_DEPTH];
  logic    mem_last [`BUF_DEPTH];
  pkt_id_t mem_id   [`BUF_DEPTH];
  port_t   mem_port [`BUF_DEPTH];

  logic [AW:0] wr_ptr;  // Extra bit tells full from empty
  logic [AW:0] rd_ptr;
  logic        pop_ok;

  assign pop_ok       = buf_rd.pop && buf_rd.avail;
  assign buf_rd.avail = (wr_ptr != rd_ptr);

  // Head beat
  assign buf_rd.data = mem_data[rd_ptr[AW-1:0]];
  assign buf_rd.keep = mem_keep[rd_ptr[AW-1:0]];
  assign buf_rd.last = mem_last[rd_ptr[AW-1:0]];
  assign buf_rd.id   = mem_id[rd_ptr[AW-1:0]];
  assign buf_rd.port = mem_port[rd_ptr[AW-1:0]];

  always_ff @(posedge axi_aclk) begin
    if (buf_wr.valid) begin
      mem_data[wr_ptr[AW-1:0]] <= buf_wr.data;
      mem_keep[wr_ptr[AW-1:0]] <= buf_wr.keep;
      mem_last[wr_ptr[AW-1:0]] <= buf_wr.last;
      mem_id[wr_ptr[AW-1:0]]   <= buf_wr.id;
      mem_port[wr_ptr[AW-1:0]] <= buf_wr.port;
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (rst) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      buf_wr.credit <= 1'b0;
    end else begin
      if (buf_wr.valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      buf_wr.credit <= pop_ok;  // Slot handed back to ingress
    end
  end

endmodule

// File: verilog/pkt_decoder_ifs.sv
`timescale 1ns/10ps

//////////////////////////////
// Ingress to buffer
//////////////////////////////
interface buf_wr_if;
  logic                     valid;
  pkt_decoder_pkg::data_t   data;
  pkt_decoder_pkg::keep_t   keep;
  logic                     last;
  pkt_decoder_pkg::pkt_id_t id;
  pkt_decoder_pkg::port_t   port;    // Source port of the beat
  logic                     credit;  // One pulse per beat popped

  modport src  (output valid, data, keep, last, id, port, input credit);
  modport sink (input valid, data, keep, last, id, port, output credit);
endinterface

//////////////////////////////
// Buffer head to egress
//////////////////////////////
interface buf_rd_if;
  logic                     avail;
  pkt_decoder_pkg::data_t   data;
  pkt_decoder_pkg::keep_t   keep;
  logic                     last;
  pkt_decoder_pkg::pkt_id_t id;
  pkt_decoder_pkg::port_t   port;
  logic                     pop;

  modport src  (output avail, data, keep, last, id, port, input pop);
  modport sink (input avail, data, keep, last, id, port, output pop);
endinterface

// Arbiter to statistics bank
interface stat_bank_if;
  logic                         en;
  pkt_decoder_pkg::stat_entry_t entry;
  logic                         wr;
  logic                         half;       // 0 packets, 1 bytes
  pkt_decoder_pkg::count_t      wdata;
  pkt_decoder_pkg::byte_cnt_t   add_bytes;
  pkt_decoder_pkg::count_t      rdata;

  modport master (output en, entry, wr, half, wdata, add_bytes, input rdata);
  modport slave  (input en, entry, wr, half, wdata, add_bytes, output rdata);
endinterface

// File: verilog/pkt_decoder_params.svh
`ifndef PKT_DECODER_PARAMS_SVH
`define PKT_DECODER_PARAMS_SVH

// Stream and buffer sizing
`define DATA_BYTES 8
`define BUF_DEPTH  16
`define CREDIT_W   5
`define PKT_ID_W   2
`define CNT_W      32

//////////////////////////////
// One-hot port codes
//////////////////////////////
// NIC0/NIC1, NIC2/NIC3, CPU0/CPU1 and CPU2/CPU3 forward to each other
`define PORT_NIC0 8'h01
`define PORT_NIC1 8'h04
`define PORT_NIC2 8'h10
`define PORT_NIC3 8'h40
`define PORT_CPU0 8'h02
`define PORT_CPU1 8'h08
`define PORT_CPU2 8'h20
`define PORT_CPU3 8'h80

`endif

// File: verilog/pkt_decoder_pkg.sv
package pkt_decoder_pkg;

  `include "pkt_decoder_params.svh"

  // Stream fields
  typedef logic [`DATA_BYTES*8-1:0] data_t;
  typedef logic [`DATA_BYTES-1:0]   keep_t;     // One bit per valid byte
  typedef logic [7:0]               port_t;     // One-hot port
  typedef logic [`PKT_ID_W-1:0]     pkt_id_t;

  // Statistics
  typedef logic [`CNT_W-1:0]        count_t;
  typedef logic [15:0]              byte_cnt_t; // Bytes in one packet

  typedef enum logic [1:0] {
    STAT_IN,
    STAT_PASS,
    STAT_DROP
  } stat_entry_t;

  // Bits 2:1 pick the entry and bit 0 picks packets or bytes
  typedef logic [2:0] reg_addr_t;

  // Egress FSM
  typedef enum logic [1:0] {
    EG_IDLE,
    EG_SEND,
    EG_DROP
  } eg_state_t;

endpackage

// File: verilog/pkt_decoder_top.sv
`timescale 1ns/10ps

module pkt_decoder_top (
  input  logic                       axi_aclk,
  input  logic                       rst,
  // Packets in
  input  pkt_decoder_pkg::data_t     s_axis_tdata,
  input  pkt_decoder_pkg::keep_t     s_axis_tkeep,
  input  pkt_decoder_pkg::port_t     s_axis_tuser,
  input  logic                       s_axis_tvalid,
  input  logic                       s_axis_tlast,
  output logic                       s_axis_tready,
  // Headers to filter
  output pkt_decoder_pkg::data_t     m_hdr_tdata,
  output pkt_decoder_pkg::pkt_id_t   m_hdr_tid,
  output logic                       m_hdr_tvalid,
  input  logic                       m_hdr_tready,
  // Decisions from filter
  input  logic                       s_dec_pass,
  input  pkt_decoder_pkg::pkt_id_t   s_dec_id,
  input  logic                       s_dec_tvalid,
  output logic                       s_dec_tready,
  // Packets out
  output pkt_decoder_pkg::data_t     m_axis_tdata,
  output pkt_decoder_pkg::keep_t     m_axis_tkeep,
  output pkt_decoder_pkg::port_t     m_axis_tuser,
  output logic                       m_axis_tvalid,
  output logic                       m_axis_tlast,
  input  logic                       m_axis_tready,
  // Host register port
  input  logic                       reg_req,
  input  logic                       reg_wr,
  input  pkt_decoder_pkg::reg_addr_t reg_addr,
  input  pkt_decoder_pkg::count_t    reg_wdata,
  output pkt_decoder_pkg::count_t    reg_rdata,
  output logic                       reg_ack
);
  import pkt_decoder_pkg::*;

  // Statistics events
  logic      in_req;
  byte_cnt_t in_bytes;
  logic      in_gnt;
  logic      eg_req;
  logic      eg_pass;
  byte_cnt_t eg_bytes;
  logic      eg_gnt;

  buf_wr_if    buf_wr ();
  buf_rd_if    buf_rd ();
  stat_bank_if bank ();

  //////////////////////////////
  // Packet path
  //////////////////////////////
  pkt_ingress u_ingress (.*);
  pkt_buffer  u_buffer  (.*);
  pkt_egress  u_egress  (.*);

  // Shared counters
  stats_arbiter u_arbiter (.*);
  stats_bank    u_bank    (.*);

endmodule

// File: verilog/pkt_egress.sv
`timescale 1ns/10ps
`include "pkt_decoder_params.svh"

module pkt_egress (
  input  logic                       axi_aclk,
  input  logic                       rst,
  buf_rd_if.sink                     buf_rd,
  input  logic                       s_dec_pass,
  input  pkt_decoder_pkg::pkt_id_t   s_dec_id,
  input  logic                       s_dec_tvalid,
  output logic                       s_dec_tready,
  output pkt_decoder_pkg::data_t     m_axis_tdata,
  output pkt_decoder_pkg::keep_t     m_axis_tkeep,
  output pkt_decoder_pkg::port_t     m_axis_tuser,
  output logic                       m_axis_tvalid,
  output logic                       m_axis_tlast,
  input  logic                       m_axis_tready,
  output logic                       eg_req,
  output logic                       eg_pass,
  output pkt_decoder_pkg::byte_cnt_t eg_bytes,
  input  logic                       eg_gnt
);
  import pkt_decoder_pkg::*;

  eg_state_t state;
  byte_cnt_t byte_acc;
  byte_cnt_t beat_bytes;
  logic      dec_ok;

  // Fixed output port table
  function automatic port_t map_port(input port_t src);
    case (src)
      `PORT_NIC0: map_port = `PORT_NIC1;
      `PORT_NIC1: map_port = `PORT_NIC0;
      `PORT_NIC2: map_port = `PORT_NIC3;
      `PORT_NIC3: map_port = `PORT_NIC2;
      `PORT_CPU0: map_port = `PORT_CPU1;
      `PORT_CPU1: map_port = `PORT_CPU0;
      `PORT_CPU2: map_port = `PORT_CPU3;
      `PORT_CPU3: map_port = `PORT_CPU2;
      default:    map_port = '0;
    endcase
  endfunction

  // One decision per packet, only once the last stats update is taken
  assign s_dec_tready = (state == EG_IDLE) && buf_rd.avail && !eg_req;
  assign dec_ok       = s_dec_tvalid && s_dec_tready;

  //////////////////////////////
  // Output stream
  //////////////////////////////
  assign m_axis_tvalid = (state == EG_SEND) && buf_rd.avail;
  assign m_axis_tdata  = buf_rd.data;  // Head stays put until popped
  assign m_axis_tkeep  = buf_rd.keep;
  assign m_axis_tlast  = buf_rd.last;
  assign m_axis_tuser  = map_port(buf_rd.port);

  assign buf_rd.pop = (m_axis_tvalid && m_axis_tready)
                      || ((state == EG_DROP) && buf_rd.avail);
  assign beat_bytes = byte_cnt_t'($countones(buf_rd.keep));

  always_ff @(posedge axi_aclk) begin
    if (rst) begin
      state    <= EG_IDLE;
      byte_acc <= '0;
      eg_req   <= 1'b0;
    end else begin
      if (eg_gnt) begin
        eg_req <= 1'b0;
      end
      case (state)
        EG_IDLE: begin
          // Decision for another id is thrown away
          if (dec_ok && (s_dec_id == buf_rd.id)) begin
            state <= s_dec_pass ? EG_SEND : EG_DROP;
          end
        end
        default: begin
          if (buf_rd.pop) begin
            if (buf_rd.last) begin
              eg_req   <= 1'b1;
              byte_acc <= '0;
              state    <= EG_IDLE;
            end else begin
              byte_acc <= byte_acc + beat_bytes;
            end
          end
        end
      endcase
    end
  end

  // Stats fields held until granted
  always_ff @(posedge axi_aclk) begin
    if (buf_rd.pop && buf_rd.last) begin
      eg_bytes <= byte_acc + beat_bytes;
      eg_pass  <= (state == EG_SEND);
    end
  end

endmodule

// File: verilog/pkt_ingress.sv
`timescale 1ns/10ps
`include "pkt_decoder_params.svh"

module pkt_ingress (
  input  logic                       axi_aclk,
  input  logic                       rst,
  input  pkt_decoder_pkg::data_t     s_axis_tdata,
  input  pkt_decoder_pkg::keep_t     s_axis_tkeep,
  input  pkt_decoder_pkg::port_t     s_axis_tuser,
  input  logic                       s_axis_tvalid,
  input  logic                       s_axis_tlast,
  output logic                       s_axis_tready,
  output pkt_decoder_pkg::data_t     m_hdr_tdata,
  output pkt_decoder_pkg::pkt_id_t   m_hdr_tid,
  output logic                       m_hdr_tvalid,
  input  logic                       m_hdr_tready,
  buf_wr_if.src                      buf_wr,
  output logic                       in_req,
  output pkt_decoder_pkg::byte_cnt_t in_bytes,
  input  logic                       in_gnt
);
  import pkt_decoder_pkg::*;

  logic [`CREDIT_W-1:0] credits;     // Free buffer slots
  pkt_id_t              next_id;
  logic                 sop;         // Next beat opens a packet
  logic                 active;
  logic                 beat_ok;
  byte_cnt_t            byte_acc;
  byte_cnt_t            beat_bytes;

  // Reverse the bytes inside each 32-bit IP field
  function automatic data_t swap_ip_bytes(input data_t d);
    data_t r;
    for (int i = 0; i < `DATA_BYTES; i++) begin
      r[8*i +: 8] = d[8*((i/4)*4 + 3 - i%4) +: 8];
    end
    return r;
  endfunction

  //////////////////////////////
  // Input handshake
  //////////////////////////////
  assign s_axis_tready = active && (credits != '0)
                         && !(sop && m_hdr_tvalid)     // Header slot still full
                         && !(in_req && s_axis_tlast); // Stats slot still full
  assign beat_ok    = s_axis_tvalid && s_axis_tready;
  assign beat_bytes = byte_cnt_t'($countones(s_axis_tkeep));

  // Beats go straight into the buffer, credits guarantee room
  assign buf_wr.valid = beat_ok;
  assign buf_wr.data  = s_axis_tdata;
  assign buf_wr.keep  = s_axis_tkeep;
  assign buf_wr.last  = s_axis_tlast;
  assign buf_wr.id    = sop ? next_id : m_hdr_tid;  // Body beats reuse the header id
  assign buf_wr.port  = s_axis_tuser;

  always_ff @(posedge axi_aclk) begin
    if (rst) begin
      active       <= 1'b0;
      credits      <= `CREDIT_W'(`BUF_DEPTH);
      next_id      <= '0;
      sop          <= 1'b1;
      m_hdr_tvalid <= 1'b0;
      in_req       <= 1'b0;
      byte_acc     <= '0;
    end else begin
      active <= 1'b1;  // Ready opens one cycle after reset

      case ({buf_wr.credit, beat_ok})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: ;
      endcase

      if (m_hdr_tready) begin
        m_hdr_tvalid <= 1'b0;
      end
      if (in_gnt) begin
        in_req <= 1'b0;
      end

      if (beat_ok) begin
        sop <= s_axis_tlast;
        if (sop) begin
          m_hdr_tvalid <= 1'b1;
          next_id      <= next_id + 1'b1;
        end
        if (s_axis_tlast) begin
          in_req   <= 1'b1;
          byte_acc <= '0;
        end else begin
          byte_acc <= byte_acc + beat_bytes;
        end
      end
    end
  end

  // Header and byte total
  always_ff @(posedge axi_aclk) begin
    if (beat_ok && sop) begin
      m_hdr_tdata <= swap_ip_bytes(s_axis_tdata);
      m_hdr_tid   <= next_id;
    end
    if (beat_ok && s_axis_tlast) begin
      in_bytes <= byte_acc + beat_bytes;
    end
  end

endmodule

// File: verilog/stats_arbiter.sv
`timescale 1ns/10ps

module stats_arbiter (
  input  logic                       axi_aclk,
  input  logic                       rst,
  input  logic                       in_req,
  input  pkt_decoder_pkg::byte_cnt_t in_bytes,
  output logic                       in_gnt,
  input  logic                       eg_req,
  input  logic                       eg_pass,
  input  pkt_decoder_pkg::byte_cnt_t eg_bytes,
  output logic                       eg_gnt,
  input  logic                       reg_req,
  input  logic                       reg_wr,
  input  pkt_decoder_pkg::reg_addr_t reg_addr,
  input  pkt_decoder_pkg::count_t    reg_wdata,
  output pkt_decoder_pkg::count_t    reg_rdata,
  output logic                       reg_ack,
  stat_bank_if.master                bank
);
  import pkt_decoder_pkg::*;

  logic [1:0] prio;  // Requester checked first
  logic [2:0] req;   // Ingress, egress, host
  logic [2:0] gnt;

  // Host request is still up in its ack cycle
  assign req = {reg_req && !reg_ack, eg_req, in_req};

  always_comb begin
    int idx;
    gnt = '0;
    for (int k = 0; k < 3; k++) begin
      idx = (int'(prio) + k) % 3;
      if ((gnt == '0) && req[idx]) begin
        gnt[idx] = 1'b1;
      end
    end
  end

  assign in_gnt = gnt[0];
  assign eg_gnt = gnt[1];

  //////////////////////////////
  // Bank command
  //////////////////////////////
  assign bank.en        = gnt[0] || gnt[1] || (gnt[2] && reg_wr); // Reads leave counters alone
  assign bank.wr        = gnt[2] && reg_wr;
  assign bank.half      = reg_addr[0];
  assign bank.wdata     = reg_wdata;
  assign bank.add_bytes = gnt[1] ? eg_bytes : in_bytes;
  assign bank.entry     = gnt[2] ? stat_entry_t'(reg_addr[2:1]) :
                          gnt[1] ? (eg_pass ? STAT_PASS : STAT_DROP) :
                                   STAT_IN;

  always_ff @(posedge axi_aclk) begin
    if (rst) begin
      prio    <= 2'd0;
      reg_ack <= 1'b0;
    end else begin
      reg_ack <= gnt[2];
      // Winner drops to last place
      if (gnt[0]) begin
        prio <= 2'd1;
      end else if (gnt[1]) begin
        prio <= 2'd2;
      end else if (gnt[2]) begin
        prio <= 2'd0;
      end
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (gnt[2]) begin
      reg_rdata <= bank.rdata;
    end
  end

endmodule

// File: verilog/stats_bank.sv
`timescale 1ns/10ps

module stats_bank (
  input logic        axi_aclk,
  input logic        rst,
  stat_bank_if.slave bank
);
  import pkt_decoder_pkg::*;

  count_t pkt_cnt  [3];
  count_t byte_cnt [3];
  logic   sel_ok;       // Address 3 has no entry

  assign sel_ok     = bank.entry inside {STAT_IN, STAT_PASS, STAT_DROP};
  assign bank.rdata = !sel_ok   ? '0 :
                      bank.half ? byte_cnt[bank.entry] : pkt_cnt[bank.entry];

  always_ff @(posedge axi_aclk) begin
    if (rst) begin
      for (int i = 0; i < 3; i++) begin
        pkt_cnt[i]  <= '0;
        byte_cnt[i] <= '0;
      end
    end else if (bank.en && sel_ok) begin
      if (!bank.wr) begin
        // One packet plus its bytes
        pkt_cnt[bank.entry]  <= pkt_cnt[bank.entry] + 1'b1;
        byte_cnt[bank.entry] <= byte_cnt[bank.entry] + count_t'(bank.add_bytes);
      end else if (bank.half) begin
        byte_cnt[bank.entry] <= bank.wdata;
      end else begin
        pkt_cnt[bank.entry] <= bank.wdata;
      end
    end
  end

endmodule
